// File: verilog/id_config.svh
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// Datapath width, shared by register values and addresses
`define ID_XLEN 32

// Register file geometry
`define ID_REG_ADDR_W 5
`define ID_NUM_REGS 32

// One-hot ALU operation sent to EXE
`define ID_ALU_OP_W 12

// Memory op, taken from opcode bits 25:22 of loads and stores
`define ID_MEM_OP_W 4

// bl writes its return address here
`define ID_RA_REG 1

`endif

// File: verilog/id_pkg.sv
`include "id_config.svh"

package id_pkg;

    // Register value or address
    typedef logic [`ID_XLEN-1:0] word_t;

    // Raw instruction word from fetch
    typedef logic [31:0] inst_t;

    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [`ID_ALU_OP_W-1:0] alu_op_t;

    typedef logic [`ID_MEM_OP_W-1:0] mem_op_t;

    // Bit positions inside alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

endpackage

// File: verilog/inst_decoder.sv
`timescale 1ns/100ps
`include "id_config.svh"

module inst_decoder
    import id_pkg::*;
(
    input  inst_t     inst,
    output alu_op_t   alu_op,
    output logic      src1_is_pc,
    output logic      src2_is_imm,
    output logic      src_reg_is_rd,
    output logic      need_r1,
    output logic      need_r2,
    output word_t     imm,
    output word_t     br_offs,
    output logic      res_from_mem,
    output mem_op_t   mem_op,
    output logic      gr_we,
    output reg_addr_t dest,
    output logic      is_jirl,
    output logic      is_b_uncond,
    output logic      is_beq,
    output logic      is_bne,
    output logic      is_blt,
    output logic      is_bge,
    output logic      is_bltu,
    output logic      is_bgeu
);

    // Opcode fields
    wire [5:0]  op_31_26 = inst[31:26];
    wire [3:0]  op_25_22 = inst[25:22];
    wire [1:0]  op_21_20 = inst[21:20];
    wire [4:0]  op_19_15 = inst[19:15];
    wire reg_addr_t rd   = inst[4:0];

    // Immediate fields
    wire [4:0]  ui5 = inst[14:10];
    wire [11:0] i12 = inst[21:10];
    wire [15:0] i16 = inst[25:10];
    wire [19:0] i20 = inst[24:5];
    wire [25:0] i26 = {inst[9:0], inst[25:10]};

    // Three-register ALU ops
    wire ty_r       = (op_31_26 == 6'h00) & (op_25_22 == 4'h0) & (op_21_20 == 2'h1);
    wire inst_add_w = ty_r & (op_19_15 == 5'h00);
    wire inst_sub_w = ty_r & (op_19_15 == 5'h02);
    wire inst_slt   = ty_r & (op_19_15 == 5'h04);
    wire inst_sltu  = ty_r & (op_19_15 == 5'h05);
    wire inst_nor   = ty_r & (op_19_15 == 5'h08);
    wire inst_and   = ty_r & (op_19_15 == 5'h09);
    wire inst_or    = ty_r & (op_19_15 == 5'h0a);
    wire inst_xor   = ty_r & (op_19_15 == 5'h0b);
    wire inst_sll_w = ty_r & (op_19_15 == 5'h0e);
    wire inst_srl_w = ty_r & (op_19_15 == 5'h0f);
    wire inst_sra_w = ty_r & (op_19_15 == 5'h10);

    // Shifts by ui5
    wire ty_s        = (op_31_26 == 6'h00) & (op_25_22 == 4'h1) & (op_21_20 == 2'h0);
    wire inst_slli_w = ty_s & (op_19_15 == 5'h01);
    wire inst_srli_w = ty_s & (op_19_15 == 5'h09);
    wire inst_srai_w = ty_s & (op_19_15 == 5'h11);

    // Register-immediate ALU ops
    wire ty_i        = (op_31_26 == 6'h00) & op_25_22[3];
    wire inst_slti   = ty_i & (op_25_22 == 4'h8);
    wire inst_sltui  = ty_i & (op_25_22 == 4'h9);
    wire inst_addi_w = ty_i & (op_25_22 == 4'ha);
    wire inst_andi   = ty_i & (op_25_22 == 4'hd);
    wire inst_ori    = ty_i & (op_25_22 == 4'he);
    wire inst_xori   = ty_i & (op_25_22 == 4'hf);

    // Loads and stores share the major opcode
    wire ty_m    = (op_31_26 == 6'h0a);
    wire inst_ld = ty_m & (op_25_22 inside {4'h0, 4'h1, 4'h2, 4'h8, 4'h9});
    wire inst_st = ty_m & (op_25_22 inside {4'h4, 4'h5, 4'h6});

    wire inst_lu12i_w   = (inst[31:25] == 7'b0001010);
    wire inst_pcaddu12i = (inst[31:25] == 7'b0001110);

    wire inst_b  = (op_31_26 == 6'h14);
    wire inst_bl = (op_31_26 == 6'h15);
    wire br_cond = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;

    wire logic_imm = inst_andi | inst_ori | inst_xori;
    wire need_si12 = (ty_i & ~logic_imm) | inst_ld | inst_st;
    wire need_si20 = inst_lu12i_w | inst_pcaddu12i;
    wire src2_is_4 = is_jirl | inst_bl;

    wire inst_known = (|alu_op) | br_cond | inst_b;

    assign is_jirl     = (op_31_26 == 6'h13);
    assign is_b_uncond = inst_b | inst_bl;
    assign is_beq      = (op_31_26 == 6'h16);
    assign is_bne      = (op_31_26 == 6'h17);
    assign is_blt      = (op_31_26 == 6'h18);
    assign is_bge      = (op_31_26 == 6'h19);
    assign is_bltu     = (op_31_26 == 6'h1a);
    assign is_bgeu     = (op_31_26 == 6'h1b);

    always_comb begin
        alu_op           = '0;
        alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld | inst_st |
                           is_jirl | inst_bl | inst_pcaddu12i;
        alu_op[ALU_SUB]  = inst_sub_w;
        alu_op[ALU_SLT]  = inst_slt | inst_slti;
        alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
        alu_op[ALU_AND]  = inst_and | inst_andi;
        alu_op[ALU_NOR]  = inst_nor;
        alu_op[ALU_OR]   = inst_or | inst_ori;
        alu_op[ALU_XOR]  = inst_xor | inst_xori;
        alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
        alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
        alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
        alu_op[ALU_LUI]  = inst_lu12i_w;
    end

    // Link value 4 wins over the other immediate kinds
    assign imm = ~inst_known ? '0 :
                 src2_is_4   ? word_t'(4) :
                 need_si20   ? {i20, 12'b0} :
                 need_si12   ? {{20{i12[11]}}, i12} :
                 logic_imm   ? {20'b0, i12} :
                 ty_s        ? {27'b0, ui5} :
                 '0;

    assign br_offs = is_b_uncond          ? {{4{i26[25]}}, i26, 2'b0} :
                     (is_jirl | br_cond)  ? {{14{i16[15]}}, i16, 2'b0} :
                     '0;

    assign src1_is_pc    = is_jirl | inst_bl | inst_pcaddu12i;
    assign src2_is_imm   = inst_known &
                           (ty_s | ty_i | inst_ld | inst_st | need_si20 | src2_is_4);
    assign src_reg_is_rd = inst_st | br_cond;

    // lu12i.w, pcaddu12i, b and bl read no rj
    assign need_r1 = inst_known &
                     (ty_r | ty_s | ty_i | inst_ld | inst_st | is_jirl | br_cond);
    assign need_r2 = inst_known & (ty_r | inst_st | br_cond);

    assign res_from_mem = inst_ld;
    assign mem_op       = (inst_ld | inst_st) ? op_25_22 : '0;
    assign gr_we        = inst_known & ~(inst_st | br_cond | inst_b);
    assign dest         = ~inst_known ? '0 :
                          inst_bl     ? reg_addr_t'(`ID_RA_REG) : rd;

endmodule

// File: verilog/regfile.sv
`timescale 1ns/100ps
`include "id_config.svh"

module regfile (
    input  logic                      clk,
    input  logic [`ID_REG_ADDR_W-1:0] raddr1,
    input  logic [`ID_REG_ADDR_W-1:0] raddr2,
    output logic [`ID_XLEN-1:0]       rdata1,
    output logic [`ID_XLEN-1:0]       rdata2,
    input  logic                      we,
    input  logic [`ID_REG_ADDR_W-1:0] waddr,
    input  logic [`ID_XLEN-1:0]       wdata
);

    logic [`ID_XLEN-1:0] regs [`ID_NUM_REGS];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational reads, r0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: verilog/operand_forward.sv
`timescale 1ns/100ps

module operand_forward
    import id_pkg::*;
(
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  logic      need_r1,
    input  logic      need_r2,
    input  logic      exe_rf_we,
    input  reg_addr_t exe_rf_waddr,
    input  word_t     exe_rf_wdata,
    input  logic      exe_res_from_mem,
    input  logic      mem_rf_we,
    input  reg_addr_t mem_rf_waddr,
    input  word_t     mem_rf_wdata,
    input  logic      mem_res_from_mem,
    input  logic      wb_rf_we,
    input  reg_addr_t wb_rf_waddr,
    input  word_t     wb_rf_wdata,
    output word_t     rj_value,
    output word_t     rkd_value,
    output logic      stall
);

    // Source matches a pending write, r0 never matches
    function automatic logic src_hit(input reg_addr_t src, input logic we,
                                     input reg_addr_t waddr);
        return (src != '0) && we && (src == waddr);
    endfunction

    logic r1_exe, r1_mem, r1_wb;
    logic r2_exe, r2_mem, r2_wb;

    assign r1_exe = src_hit(raddr1, exe_rf_we, exe_rf_waddr);
    assign r1_mem = src_hit(raddr1, mem_rf_we, mem_rf_waddr);
    assign r1_wb  = src_hit(raddr1, wb_rf_we, wb_rf_waddr);
    assign r2_exe = src_hit(raddr2, exe_rf_we, exe_rf_waddr);
    assign r2_mem = src_hit(raddr2, mem_rf_we, mem_rf_waddr);
    assign r2_wb  = src_hit(raddr2, wb_rf_we, wb_rf_waddr);

    // Youngest producer first
    assign rj_value  = r1_exe ? exe_rf_wdata :
                       r1_mem ? mem_rf_wdata :
                       r1_wb  ? wb_rf_wdata  : rf_rdata1;
    assign rkd_value = r2_exe ? exe_rf_wdata :
                       r2_mem ? mem_rf_wdata :
                       r2_wb  ? wb_rf_wdata  : rf_rdata2;

    // Load data not back yet in EXE or MEM
    assign stall = (exe_res_from_mem & ((r1_exe & need_r1) | (r2_exe & need_r2))) |
                   (mem_res_from_mem & ((r1_mem & need_r1) | (r2_mem & need_r2)));

endmodule

// File: verilog/branch_unit.sv
`timescale 1ns/100ps

module branch_unit
    import id_pkg::*;
(
    input  word_t rj_value,
    input  word_t rkd_value,
    input  word_t pc,
    input  word_t br_offs,
    input  logic  is_jirl,
    input  logic  is_b_uncond,
    input  logic  is_beq,
    input  logic  is_bne,
    input  logic  is_blt,
    input  logic  is_bge,
    input  logic  is_bltu,
    input  logic  is_bgeu,
    output logic  cond_met,
    output word_t br_target
);

    logic rj_eq_rd;
    logic rj_lt_rd;
    logic rj_ltu_rd;

    assign rj_eq_rd  = (rj_value == rkd_value);
    assign rj_lt_rd  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu_rd = (rj_value < rkd_value);

    // Jumps are always taken
    assign cond_met = (is_beq  &  rj_eq_rd)  |
                      (is_bne  & ~rj_eq_rd)  |
                      (is_blt  &  rj_lt_rd)  |
                      (is_bge  & ~rj_lt_rd)  |
                      (is_bltu &  rj_ltu_rd) |
                      (is_bgeu & ~rj_ltu_rd) |
                      is_jirl | is_b_uncond;

    // jirl is register relative, the rest PC relative
    assign br_target = (is_jirl ? rj_value : pc) + br_offs;

endmodule

// File: verilog/id_stage.sv
`timescale 1ns/100ps

module id_stage
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      if_to_id_valid,
    input  inst_t     inst,
    input  word_t     pc,
    output logic      id_allowin,
    output logic      br_taken,
    output word_t     br_target,
    input  logic      exe_allowin,
    output logic      id_to_exe_valid,
    output alu_op_t   alu_op,
    output word_t     alu_src1,
    output word_t     alu_src2,
    output logic      res_from_mem,
    output mem_op_t   mem_op,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     store_data,
    output word_t     exe_pc,
    input  logic      exe_rf_we,
    input  reg_addr_t exe_rf_waddr,
    input  word_t     exe_rf_wdata,
    input  logic      exe_res_from_mem,
    input  logic      mem_rf_we,
    input  reg_addr_t mem_rf_waddr,
    input  word_t     mem_rf_wdata,
    input  logic      mem_res_from_mem,
    input  logic      wb_rf_we,
    input  reg_addr_t wb_rf_waddr,
    input  word_t     wb_rf_wdata
);

    logic      id_valid;
    inst_t     id_inst;
    word_t     id_pc;
    logic      stall;
    logic      cond_met;
    logic      src1_is_pc, src2_is_imm, src_reg_is_rd;
    logic      need_r1, need_r2, gr_we;
    logic      is_jirl, is_b_uncond, is_beq, is_bne;
    logic      is_blt, is_bge, is_bltu, is_bgeu;
    word_t     imm, br_offs;
    word_t     rf_rdata1, rf_rdata2;
    word_t     rj_value, rkd_value;
    reg_addr_t rf_raddr1, rf_raddr2;

    assign id_allowin      = ~id_valid | (~stall & exe_allowin);
    assign id_to_exe_valid = id_valid & ~stall;
    assign br_taken        = cond_met & id_valid & ~stall & exe_allowin;

    // A taken branch empties the stage and drops the fetch beat
    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= if_to_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin && !br_taken) begin
            id_inst <= inst;
            id_pc   <= pc;
        end
    end

    // Stores and conditional branches read rd as the second source
    assign rf_raddr1 = id_inst[9:5];
    assign rf_raddr2 = src_reg_is_rd ? id_inst[4:0] : id_inst[14:10];

    assign alu_src1   = src1_is_pc ? id_pc : rj_value;
    assign alu_src2   = src2_is_imm ? imm : rkd_value;
    assign store_data = rkd_value;
    assign exe_pc     = id_pc;
    assign rf_we      = gr_we & id_valid;

    inst_decoder u_decoder (
        .inst(id_inst), .alu_op(alu_op),
        .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm),
        .src_reg_is_rd(src_reg_is_rd), .need_r1(need_r1), .need_r2(need_r2),
        .imm(imm), .br_offs(br_offs), .res_from_mem(res_from_mem),
        .mem_op(mem_op), .gr_we(gr_we), .dest(rf_waddr),
        .is_jirl(is_jirl), .is_b_uncond(is_b_uncond),
        .is_beq(is_beq), .is_bne(is_bne), .is_blt(is_blt),
        .is_bge(is_bge), .is_bltu(is_bltu), .is_bgeu(is_bgeu)
    );

    regfile u_regfile (
        .clk(clk), .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(wb_rf_we), .waddr(wb_rf_waddr), .wdata(wb_rf_wdata)
    );

    operand_forward u_forward (
        .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .need_r1(need_r1), .need_r2(need_r2),
        .exe_rf_we(exe_rf_we), .exe_rf_waddr(exe_rf_waddr),
        .exe_rf_wdata(exe_rf_wdata), .exe_res_from_mem(exe_res_from_mem),
        .mem_rf_we(mem_rf_we), .mem_rf_waddr(mem_rf_waddr),
        .mem_rf_wdata(mem_rf_wdata), .mem_res_from_mem(mem_res_from_mem),
        .wb_rf_we(wb_rf_we), .wb_rf_waddr(wb_rf_waddr), .wb_rf_wdata(wb_rf_wdata),
        .rj_value(rj_value), .rkd_value(rkd_value), .stall(stall)
    );

    branch_unit u_branch (
        .rj_value(rj_value), .rkd_value(rkd_value), .pc(id_pc), .br_offs(br_offs),
        .is_jirl(is_jirl), .is_b_uncond(is_b_uncond),
        .is_beq(is_beq), .is_bne(is_bne), .is_blt(is_blt),
        .is_bge(is_bge), .is_bltu(is_bltu), .is_bgeu(is_bgeu),
        .cond_met(cond_met), .br_target(br_target)
    );

endmodule

// File: verification/id_stage_asserts.sv
`timescale 1ns/100ps

module id_stage_asserts
    import id_pkg::*;
(
    input logic      clk,
    input logic      resetn,
    input logic      id_valid,
    input logic      stall,
    input logic      exe_allowin,
    input logic      id_to_exe_valid,
    input logic      br_taken,
    input alu_op_t   alu_op,
    input word_t     alu_src1,
    input word_t     alu_src2,
    input mem_op_t   mem_op,
    input logic      rf_we,
    input reg_addr_t rf_waddr,
    input word_t     store_data,
    input word_t     exe_pc
);

    // A stalled instruction stays in decode
    stall_holds_inst: assert property (@(posedge clk) disable iff (!resetn)
        (id_valid && stall) |=> (id_valid && $stable(exe_pc)))
        else $error("instruction lost during a load-use stall");

    // Taken branch leaves the stage empty
    taken_empties_stage: assert property (@(posedge clk) disable iff (!resetn)
        br_taken |=> !id_valid)
        else $error("decode still valid after a taken branch");

    // EXE not ready, whole payload holds
    payload_held: assert property (@(posedge clk) disable iff (!resetn)
        (id_to_exe_valid && !exe_allowin) |=>
            (id_to_exe_valid && $stable({alu_op, alu_src1, alu_src2, mem_op, rf_we,
                                         rf_waddr, store_data, exe_pc})))
        else $error("payload changed under back-pressure");

endmodule

bind id_stage id_stage_asserts u_asserts (
    .clk(clk), .resetn(resetn), .id_valid(id_valid), .stall(stall),
    .exe_allowin(exe_allowin), .id_to_exe_valid(id_to_exe_valid), .br_taken(br_taken),
    .alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2), .mem_op(mem_op),
    .rf_we(rf_we), .rf_waddr(rf_waddr), .store_data(store_data), .exe_pc(exe_pc)
);

// File: verification/tb_id_stage.sv
`timescale 1ns/100ps

module tb_id_stage
    import id_pkg::*;
();

    // Rough cycle cost: reset, alu, imm, fwd, stall, branches, store
    localparam int TEST_CYCLES = 10 + 20 + 25 + 20 + 15 + 130 + 15;
    localparam int CYCLE_LIMIT = TEST_CYCLES + 100;

    logic clk, resetn, if_to_id_valid, id_allowin, br_taken, exe_allowin;
    logic id_to_exe_valid, res_from_mem, rf_we;
    inst_t inst;
    word_t pc, br_target, alu_src1, alu_src2, store_data, exe_pc;
    alu_op_t alu_op;
    mem_op_t mem_op;
    reg_addr_t rf_waddr, exe_rf_waddr, mem_rf_waddr, wb_rf_waddr;
    logic exe_rf_we, exe_res_from_mem, mem_rf_we, mem_res_from_mem, wb_rf_we;
    word_t exe_rf_wdata, mem_rf_wdata, wb_rf_wdata;
    int errors, test_errs, tests_run, tests_failed, cycles;
    integer seed;

    id_stage i_dut (.*);

    always #2 clk = ~clk;

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: tests still running after %0d cycles", cycles);
        $display("Test FAILED");
        $finish;
    end

    // Instruction formats
    function automatic inst_t enc_3r(input logic [4:0] op, input reg_addr_t rk, rj, rd);
        return {6'h00, 4'h0, 2'h1, op, rk, rj, rd};
    endfunction
    function automatic inst_t enc_shift(input logic [4:0] op, ui5, input reg_addr_t rj, rd);
        return {6'h00, 4'h1, 2'h0, op, ui5, rj, rd};
    endfunction
    function automatic inst_t enc_2ri12(input logic [5:0] op6, input logic [3:0] op4,
                                        input logic [11:0] i12, input reg_addr_t rj, rd);
        return {op6, op4, i12, rj, rd};
    endfunction
    function automatic inst_t enc_1ri20(input logic [6:0] op, input logic [19:0] si20,
                                        input reg_addr_t rd);
        return {op, si20, rd};
    endfunction
    function automatic inst_t enc_2ri16(input logic [5:0] op, input logic [15:0] i16,
                                        input reg_addr_t rj, rd);
        return {op, i16, rj, rd};
    endfunction
    function automatic inst_t enc_i26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction
    function automatic word_t offs16(input logic [15:0] v);
        return {{14{v[15]}}, v, 2'b00};
    endfunction
    function automatic word_t offs26(input logic [25:0] v);
        return {{4{v[25]}}, v, 2'b00};
    endfunction
    function automatic alu_op_t alu_bit(input int idx);
        return alu_op_t'(1) << idx;
    endfunction

    task automatic mismatch(input string name, input string got, input string exp);
        $display("ERR %0t %s got %s expected %s", $time, name, got, exp);
        test_errs++;
    endtask
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask
    task automatic check_alu_op(input string name, input alu_op_t got, input alu_op_t exp);
        if (got !== exp) mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask
    task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask
    task automatic check_mem_op(input string name, input mem_op_t got, input mem_op_t exp);
        if (got !== exp) mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask
    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        errors += test_errs;
        if (test_errs != 0) tests_failed++;
        $display("%-16s %s, %0d mismatches", name, (test_errs == 0) ? "passed" : "failed",
                 test_errs);
        test_errs = 0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(negedge clk);
        wb_rf_we = 1'b1;
        wb_rf_waddr = addr;
        wb_rf_wdata = data;
        @(negedge clk);
        wb_rf_we = 1'b0;
    endtask

    // Returns on the falling edge after capture
    task automatic send(input inst_t w, input word_t p);
        @(negedge clk);
        if_to_id_valid = 1'b1;
        inst = w;
        pc = p;
        #1;
        while (!id_allowin) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        if_to_id_valid = 1'b0;
    endtask

    task automatic wait_issue();
        while (!id_to_exe_valid) begin
            @(negedge clk);
            #1;
        end
    endtask

    task automatic alu_case(input string name, input inst_t w, input word_t p, input logic chk1,
                            input word_t exp1, exp2, input int op_idx, input reg_addr_t rd);
        send(w, p);
        #1;
        wait_issue();
        if (chk1) check_word({name, " alu_src1"}, alu_src1, exp1);
        check_word({name, " alu_src2"}, alu_src2, exp2);
        check_alu_op({name, " alu_op"}, alu_op, alu_bit(op_idx));
        check_reg_addr({name, " rf_waddr"}, rf_waddr, rd);
        check_bit({name, " rf_we"}, rf_we, 1'b1);
    endtask

    task automatic run_branch(input string name, input inst_t w, input word_t p,
                              input logic exp_taken, input word_t exp_target);
        send(w, p);
        // Offer the next fetch beat while the branch resolves
        if_to_id_valid = 1'b1;
        inst = enc_3r(5'h00, 5'd0, 5'd0, 5'd0);
        pc = p + 32'd4;
        #1;
        check_bit({name, " id_to_exe_valid"}, id_to_exe_valid, 1'b1);
        check_bit({name, " br_taken"}, br_taken, exp_taken);
        if (exp_taken) check_word({name, " br_target"}, br_target, exp_target);
        @(negedge clk);
        if_to_id_valid = 1'b0;
        #1;
        check_bit({name, " next id_to_exe_valid"}, id_to_exe_valid, !exp_taken);
    endtask

    task automatic test_register_alu();
        write_reg(5'd2, 32'h1234_5678);
        write_reg(5'd3, 32'h0f0f_00ff);
        alu_case("add.w", enc_3r(5'h00, 5'd3, 5'd2, 5'd4), 32'h1c00_0000, 1'b1,
                 32'h1234_5678, 32'h0f0f_00ff, ALU_ADD, 5'd4);
        alu_case("sub.w", enc_3r(5'h02, 5'd3, 5'd2, 5'd5), 32'h1c00_0004, 1'b1,
                 32'h1234_5678, 32'h0f0f_00ff, ALU_SUB, 5'd5);
        alu_case("xor", enc_3r(5'h0b, 5'd3, 5'd2, 5'd6), 32'h1c00_0008, 1'b1,
                 32'h1234_5678, 32'h0f0f_00ff, ALU_XOR, 5'd6);
        end_test("register_alu");
    endtask

    task automatic test_immediates();
        write_reg(5'd2, 32'h0000_1000);
        alu_case("addi.w", enc_2ri12(6'h00, 4'ha, 12'hf9c, 5'd2, 5'd10), 32'h1c00_0100,
                 1'b1, 32'h0000_1000, sext12(12'hf9c), ALU_ADD, 5'd10);
        alu_case("ori", enc_2ri12(6'h00, 4'he, 12'h8a5, 5'd2, 5'd11), 32'h1c00_0104,
                 1'b1, 32'h0000_1000, {20'h0, 12'h8a5}, ALU_OR, 5'd11);
        alu_case("slli.w", enc_shift(5'h01, 5'd7, 5'd2, 5'd12), 32'h1c00_0108,
                 1'b1, 32'h0000_1000, 32'd7, ALU_SLL, 5'd12);
        alu_case("lu12i.w", enc_1ri20(7'b0001010, 20'h81234, 5'd13), 32'h1c00_010c,
                 1'b0, '0, {20'h81234, 12'h0}, ALU_LUI, 5'd13);
        alu_case("pcaddu12i", enc_1ri20(7'b0001110, 20'h00abc, 5'd14), 32'h1c00_0110,
                 1'b1, 32'h1c00_0110, {20'h00abc, 12'h0}, ALU_ADD, 5'd14);
        alu_case("ld.w", enc_2ri12(6'h0a, 4'h2, 12'hff8, 5'd2, 5'd15), 32'h1c00_0114,
                 1'b1, 32'h0000_1000, sext12(12'hff8), ALU_ADD, 5'd15);
        check_bit("ld.w res_from_mem", res_from_mem, 1'b1);
        check_mem_op("ld.w mem_op", mem_op, 4'h2);
        end_test("immediates");
    endtask

    task automatic test_forward_priority();
        inst_t w;
        w = enc_3r(5'h00, 5'd0, 5'd8, 5'd9);
        @(negedge clk);
        exe_rf_we = 1'b1;
        exe_rf_waddr = 5'd8;
        exe_rf_wdata = 32'h1111_0001;
        mem_rf_we = 1'b1;
        mem_rf_waddr = 5'd8;
        mem_rf_wdata = 32'h2222_0002;
        wb_rf_we = 1'b1;
        wb_rf_waddr = 5'd8;
        wb_rf_wdata = 32'h3333_0003;
        alu_case("fwd exe", w, 32'h1c00_0200, 1'b1, 32'h1111_0001, '0, ALU_ADD, 5'd9);
        @(negedge clk);
        exe_rf_we = 1'b0;
        alu_case("fwd mem", w, 32'h1c00_0200, 1'b1, 32'h2222_0002, '0, ALU_ADD, 5'd9);
        @(negedge clk);
        mem_rf_we = 1'b0;
        wb_rf_we = 1'b0;
        send(w, 32'h1c00_0200);
        // Regfile still holds the older WB value here
        wb_rf_we = 1'b1;
        wb_rf_wdata = 32'h4444_0004;
        #1;
        wait_issue();
        check_word("fwd wb alu_src1", alu_src1, 32'h4444_0004);
        @(negedge clk);
        wb_rf_we = 1'b0;
        end_test("forward_priority");
    endtask

    task automatic test_load_use();
        @(negedge clk);
        exe_rf_we = 1'b1;
        exe_rf_waddr = 5'd11;
        exe_rf_wdata = 32'hdead_beef;
        exe_res_from_mem = 1'b1;
        send(enc_3r(5'h00, 5'd0, 5'd11, 5'd12), 32'h1c00_0300);
        repeat (3) begin
            #1;
            check_bit("stall id_to_exe_valid", id_to_exe_valid, 1'b0);
            check_bit("stall id_allowin", id_allowin, 1'b0);
            @(negedge clk);
        end
        // Load moves on to MEM with its data
        exe_rf_we = 1'b0;
        exe_res_from_mem = 1'b0;
        mem_rf_we = 1'b1;
        mem_rf_waddr = 5'd11;
        mem_rf_wdata = 32'h0bad_f00d;
        #1;
        wait_issue();
        check_word("load-use alu_src1", alu_src1, 32'h0bad_f00d);
        check_reg_addr("load-use rf_waddr", rf_waddr, 5'd12);
        @(negedge clk);
        mem_rf_we = 1'b0;
        end_test("load_use_stall");
    endtask

    task automatic test_branches();
        word_t a, b, p;
        p = 32'h1c00_2000;
        for (int i = 0; i < 4; i++) begin
            a = $random(seed);
            b = (i == 0) ? a : $random(seed);
            write_reg(5'd4, a);
            write_reg(5'd5, b);
            run_branch("beq", enc_2ri16(6'h16, 16'hfff0, 5'd4, 5'd5), p, a == b,
                       p + offs16(16'hfff0));
            run_branch("blt", enc_2ri16(6'h18, 16'h0021, 5'd4, 5'd5), p,
                       $signed(a) < $signed(b), p + offs16(16'h0021));
            run_branch("bgeu", enc_2ri16(6'h1b, 16'h8000, 5'd4, 5'd5), p, !(a < b),
                       p + offs16(16'h8000));
            run_branch("b", enc_i26(6'h14, 26'h000_0100), p, 1'b1, p + offs26(26'h000_0100));
            run_branch("jirl", enc_2ri16(6'h13, 16'h0010, 5'd4, 5'd1), p, 1'b1,
                       a + offs16(16'h0010));
        end
        send(enc_i26(6'h15, 26'h3ff_fff8), p);
        #1;
        wait_issue();
        check_bit("bl br_taken", br_taken, 1'b1);
        check_word("bl br_target", br_target, p + offs26(26'h3ff_fff8));
        check_reg_addr("bl rf_waddr", rf_waddr, 5'd1);
        check_bit("bl rf_we", rf_we, 1'b1);
        check_word("bl alu_src1", alu_src1, p);
        check_word("bl alu_src2", alu_src2, 32'd4);
        end_test("branches");
    endtask

    task automatic test_store_backpressure();
        write_reg(5'd6, 32'h0000_8000);
        write_reg(5'd7, 32'hcafe_0042);
        @(negedge clk);
        exe_allowin = 1'b0;
        send(enc_2ri12(6'h0a, 4'h6, 12'h024, 5'd6, 5'd7), 32'h1c00_3000);
        repeat (3) begin
            #1;
            check_bit("st.w id_to_exe_valid", id_to_exe_valid, 1'b1);
            check_bit("st.w id_allowin", id_allowin, 1'b0);
            check_word("st.w alu_src1", alu_src1, 32'h0000_8000);
            check_word("st.w alu_src2", alu_src2, sext12(12'h024));
            check_word("st.w store_data", store_data, 32'hcafe_0042);
            check_word("st.w exe_pc", exe_pc, 32'h1c00_3000);
            check_mem_op("st.w mem_op", mem_op, 4'h6);
            check_bit("st.w rf_we", rf_we, 1'b0);
            check_bit("st.w res_from_mem", res_from_mem, 1'b0);
            @(negedge clk);
        end
        exe_allowin = 1'b1;
        #1;
        while (id_to_exe_valid) begin
            @(negedge clk);
            #1;
        end
        check_bit("st.w drained id_allowin", id_allowin, 1'b1);
        end_test("store_backpressure");
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        if_to_id_valid = 1'b0;
        inst = '0;
        pc = '0;
        exe_allowin = 1'b1;
        {exe_rf_we, exe_res_from_mem, mem_rf_we, mem_res_from_mem, wb_rf_we} = '0;
        {exe_rf_waddr, mem_rf_waddr, wb_rf_waddr} = '0;
        {exe_rf_wdata, mem_rf_wdata, wb_rf_wdata} = '0;
        {errors, test_errs, tests_run, tests_failed} = '0;
        seed = 5;
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        #1;
        check_bit("reset id_allowin", id_allowin, 1'b1);
        check_bit("reset id_to_exe_valid", id_to_exe_valid, 1'b0);
        check_bit("reset br_taken", br_taken, 1'b0);
        end_test("reset");
        test_register_alu();
        test_immediates();
        test_forward_priority();
        test_load_use();
        test_branches();
        test_store_backpressure();
        $display("Summary: %0d tests, %0d failed, %0d mismatches", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+verilog
verilog/id_pkg.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/operand_forward.sv
verilog/branch_unit.sv
verilog/id_stage.sv
verification/id_stage_asserts.sv
verification/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := sim.f $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sim.f

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(BUILD_DIR)
